//--- verilog/mvu_config.svh
/*
 * MVU sizing
 * Processing element count, SIMD width, data widths and activation
 * signedness for the matrix-vector multiply unit
 */

`ifndef MVU_CONFIG_SVH
`define MVU_CONFIG_SVH

// Array shape
`define MVU_PE 2 // Processing elements, one chain each
`define MVU_SIMD 6 // Activations per beat, multiple of 3

// Data widths
`define MVU_ACT_WIDTH 4 // At most 9, fits one DSP A lane
`define MVU_WEIGHT_WIDTH 4 // At most 8, fits one DSP B lane
`define MVU_ACCU_WIDTH 24 // Width of each output total

// 1 sign-extends activations, 0 zero-extends them
`define MVU_SIGNED_ACT 1

// Slice geometry
`define MVU_LANES 3 // Lane pairs per slice, INT8 mode
`define MVU_CHAIN_LEN (`MVU_SIMD / `MVU_LANES) // Slices per chain

// Internal lane widths of the modelled DSP
`define MVU_ACT_LANE_WIDTH 9
`define MVU_WEIGHT_LANE_WIDTH 8
`define MVU_CASCADE_WIDTH 58 // PCOUT/PCIN width

`endif

//--- verilog/mvu_pkg.sv
/*
 * MVU types
 * Data vectors, lane triples, cascade word, beat sideband and
 * accumulator opcode shared across the multiply unit
 */

`include "mvu_config.svh"

package mvuPkg;

	// Full activation vector of one beat
	typedef logic [`MVU_SIMD-1:0][`MVU_ACT_WIDTH-1:0] actVec_t;

	// One weight row, belongs to a single PE
	typedef logic [`MVU_SIMD-1:0][`MVU_WEIGHT_WIDTH-1:0] weightVec_t;

	// All rows of one beat
	typedef weightVec_t [`MVU_PE-1:0] weightMat_t;

	// Output totals, one per PE
	typedef logic [`MVU_PE-1:0][`MVU_ACCU_WIDTH-1:0] accuVec_t;

	// Per-slice lane triples
	typedef logic [`MVU_LANES-1:0][`MVU_ACT_WIDTH-1:0] lanes3Act_t;
	typedef logic [`MVU_LANES-1:0][`MVU_WEIGHT_WIDTH-1:0] lanes3Weight_t;

	// Partial sum passed slice to slice
	typedef logic signed [`MVU_CASCADE_WIDTH-1:0] cascade_t;

	// Beat sideband
	typedef struct packed {
		logic last; // Closes the current vector
		logic zero; // Beat contributes nothing
	} beatCtrl_t;

	// Accumulator opcode of the last slice
	typedef enum logic {
		ACC_HOLD = 1'b0, // Add to running total
		ACC_RESTART = 1'b1 // Start over from product sum
	} accOp_e;

endpackage

//--- verilog/mvuControl.sv
/*
 * MVU control
 * Pipes the last flag alongside the datapath to form valid and the
 * accumulator restart opcode; registers the zero flag in step with
 * the slice input registers
 */

`timescale 1ns/1ps

module mvuControl import mvuPkg::*; (
	input logic clk,
	input logic rst,
	input logic en_i,
	input beatCtrl_t ctrl_i,
	output logic zero_o, // To every slice M stage
	output accOp_e accOp_o, // To last slice of each chain
	output logic valid_o
);

	// [0] input reg stage, [1] M stage, [2] accumulator stage
	logic [2:0] lastPipe;

	always_ff @(posedge clk) begin
		if (rst) begin
			lastPipe <= '0;
		end else if (en_i) begin
			lastPipe <= {lastPipe[1:0], ctrl_i.last}; // Shift toward the output
		end
	end

	// The total of a last beat forms on the edge that moves it into stage 2,
	// so the next accumulate has to start over
	always_ff @(posedge clk) begin
		if (rst) begin
			accOp_o <= ACC_HOLD;
		end else if (en_i) begin
			accOp_o <= lastPipe[1] ? ACC_RESTART : ACC_HOLD;
		end
	end

	// Lines up with the slice input registers
	always_ff @(posedge clk) begin
		if (rst) begin
			zero_o <= 1'b0;
		end else if (en_i) begin
			zero_o <= ctrl_i.zero;
		end
	end

	assign valid_o = lastPipe[2]; // Same edge as the closing total

endmodule

//--- verilog/dspSlice.sv
/*
 * DSP slice
 * Behavioral model of one DSP58 in INT8 mode: three activation/weight
 * lane pairs, input registers, M register, then either a cascade adder
 * or, at the end of a chain, the running accumulator
 */

`timescale 1ns/1ps

`include "mvu_config.svh"

module dspSlice import mvuPkg::*; #(
	parameter bit IS_FIRST = 1'b0, // No cascade input
	parameter bit IS_LAST = 1'b0 // Holds the accumulator
) (
	input logic clk,
	input logic rst,
	input logic en_i,
	input lanes3Act_t act_i,
	input lanes3Weight_t weight_i,
	input logic zero_i, // Already registered, aligned with actReg
	input accOp_e accOp_i, // Read by the last slice only
	input cascade_t cascade_i,
	output cascade_t cascade_o
);

	localparam int ACT_LANE_W = `MVU_ACT_LANE_WIDTH;
	localparam int WEIGHT_LANE_W = `MVU_WEIGHT_LANE_WIDTH;
	localparam int PROD_W = ACT_LANE_W + WEIGHT_LANE_W;

	lanes3Act_t actReg; // A input register
	lanes3Weight_t weightReg; // B input register
	logic signed [ACT_LANE_W-1:0] actWide [`MVU_LANES];
	logic signed [WEIGHT_LANE_W-1:0] weightWide [`MVU_LANES];
	logic signed [PROD_W-1:0] prod [`MVU_LANES];
	cascade_t laneSum; // Sum of the three products
	cascade_t mReg;
	cascade_t cascIn;
	cascade_t cascSum;

	// Stage 1, input registers
	always_ff @(posedge clk) begin
		if (rst) begin
			actReg <= '0; // Empty pipeline adds zero
			weightReg <= '0;
		end else if (en_i) begin
			actReg <= act_i;
			weightReg <= weight_i;
		end
	end

	// Lane widening to DSP lane widths
	always_comb begin
		for (int k = 0; k < `MVU_LANES; k++) begin
			if (`MVU_SIGNED_ACT) begin
				actWide[k] = ACT_LANE_W'(signed'(actReg[k])); // Sign extend
			end else begin
				actWide[k] = ACT_LANE_W'(actReg[k]); // Zero extend
			end
			weightWide[k] = WEIGHT_LANE_W'(signed'(weightReg[k])); // Weights always signed
		end
	end

	// Three lane multipliers and their adder
	always_comb begin
		laneSum = '0;
		for (int k = 0; k < `MVU_LANES; k++) begin
			prod[k] = actWide[k] * weightWide[k];
			laneSum = laneSum + cascade_t'(prod[k]);
		end
	end

	// Stage 2, M register
	always_ff @(posedge clk) begin
		if (rst) begin
			mReg <= '0;
		end else if (en_i) begin
			mReg <= zero_i ? '0 : laneSum; // Zero beat drops its products
		end
	end

	assign cascIn = IS_FIRST ? cascade_t'(0) : cascade_i; // Chain head sees no PCIN
	assign cascSum = mReg + cascIn;

	if (IS_LAST) begin : genAccu
		cascade_t accReg;
		cascade_t accBase;

		assign accBase = (accOp_i == ACC_RESTART) ? cascade_t'(0) : accReg;

		// Stage 3, running total across beats
		always_ff @(posedge clk) begin
			if (rst) begin
				accReg <= '0;
			end else if (en_i) begin
				accReg <= accBase + cascSum;
			end
		end

		assign cascade_o = accReg; // Chain total
	end else begin : genPass
		assign cascade_o = cascSum; // Combinational PCOUT
	end

endmodule

//--- verilog/peChain.sv
/*
 * PE chain
 * One processing element: cuts the activation and weight vectors into
 * lane triples, feeds one slice per triple and links the partial sums
 * through the cascade into the accumulating last slice
 */

`timescale 1ns/1ps

`include "mvu_config.svh"

module peChain import mvuPkg::*; (
	input logic clk,
	input logic rst,
	input logic en_i,
	input actVec_t act_i,
	input weightVec_t weight_i, // This PE's weight row
	input logic zero_i,
	input accOp_e accOp_i,
	output logic [`MVU_ACCU_WIDTH-1:0] total_o
);

	localparam int CHAIN_LEN = `MVU_CHAIN_LEN;

	cascade_t casc [CHAIN_LEN]; // PCOUT of each slice

	for (genvar i = 0; i < CHAIN_LEN; i++) begin : genSlice
		localparam bit FIRST = (i == 0);
		localparam bit LAST = (i == CHAIN_LEN - 1);

		lanes3Act_t actLanes;
		lanes3Weight_t weightLanes;
		cascade_t cascIn;

		// Lanes 3i .. 3i+2 go to slice i
		assign actLanes = act_i[`MVU_LANES*i +: `MVU_LANES];
		assign weightLanes = weight_i[`MVU_LANES*i +: `MVU_LANES];

		if (FIRST) begin : genHead
			assign cascIn = '0;
		end else begin : genLink
			assign cascIn = casc[i-1];
		end

		dspSlice #(
			.IS_FIRST(FIRST),
			.IS_LAST(LAST)
		) uSlice (
			.clk(clk),
			.rst(rst),
			.en_i(en_i),
			.act_i(actLanes),
			.weight_i(weightLanes),
			.zero_i(zero_i),
			.accOp_i(accOp_i), // Only the accumulator follows the opcode
			.cascade_i(cascIn),
			.cascade_o(casc[i])
		);
	end

	// Low bits of the last accumulator
	assign total_o = casc[CHAIN_LEN-1][`MVU_ACCU_WIDTH-1:0];

endmodule

//--- verilog/mvuTop.sv
/*
 * MVU top
 * Matrix-vector multiply unit: one control block and one slice chain
 * per processing element, all sharing the activation vector
 */

`timescale 1ns/1ps

`include "mvu_config.svh"

module mvuTop import mvuPkg::*; (
	input logic clk,
	input logic rst,
	input logic en_i, // Stall when low
	input beatCtrl_t ctrl_i,
	input actVec_t act_i,
	input weightMat_t weight_i,
	output logic valid_o,
	output accuVec_t result_o
);

	logic zeroReg; // Registered zero flag
	accOp_e accOp; // Restart opcode for accumulators

	mvuControl uControl (
		.clk(clk),
		.rst(rst),
		.en_i(en_i),
		.ctrl_i(ctrl_i),
		.zero_o(zeroReg),
		.accOp_o(accOp),
		.valid_o(valid_o)
	);

	// Same activations to every PE, own weight row each
	for (genvar p = 0; p < `MVU_PE; p++) begin : genPe
		peChain uChain (
			.clk(clk),
			.rst(rst),
			.en_i(en_i),
			.act_i(act_i),
			.weight_i(weight_i[p]),
			.zero_i(zeroReg),
			.accOp_i(accOp),
			.total_o(result_o[p])
		);
	end

endmodule

//--- tb/tbClock.sv
/*
 * Testbench clock
 * Free-running 20 ns clock for the MVU testbench
 */

`timescale 1ns/1ps

module tbClock #(
	parameter realtime HALF_PERIOD = 10ns // 20 ns period
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0; // Known level before the first edge
	end

	always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule

//--- tb/mvuChecker.sv
/*
 * MVU result checker
 * Pops one expected result per enabled valid cycle, compares every PE
 * total, prints a line per finished test and the closing counts
 */

`timescale 1ns/1ps

`include "mvu_config.svh"

module mvuChecker import mvuPkg::*; (
	input logic clk,
	input logic rst,
	input logic en_i,
	input logic valid_o,
	input accuVec_t result_o
);

	string expName [$]; // Test name per expected result
	accuVec_t expValue [$]; // Expected totals, file order
	int errorCount = 0;
	int testCount = 0;
	int failedTests = 0;
	bit testBad = 1'b0; // Current test has a mismatch

	function automatic void addExpect(input string name, input accuVec_t value);
		expName.push_back(name);
		expValue.push_back(value);
	endfunction

	function automatic int pending();
		return expName.size();
	endfunction

	// Outputs settle after the rising edge, read them mid-cycle
	always @(negedge clk) begin : compare
		string name;
		accuVec_t want;
		if (!rst && en_i && valid_o) begin
			if (expName.size() == 0) begin
				$display("valid_o pulsed at %0t with no expected result pending", $time);
				errorCount++;
			end else begin
				name = expName.pop_front();
				want = expValue.pop_front();
				for (int p = 0; p < `MVU_PE; p++) begin
					if (result_o[p] !== want[p]) begin
						$display("CHECK FAILED %s pe%0d expected %0d actual %0d", name, p,
							$signed(want[p]), $signed(result_o[p]));
						errorCount++;
						testBad = 1'b1;
					end
				end
				// Last expectation of this test name closes the test
				if (expName.size() == 0 || expName[0] != name) begin
					testCount++;
					if (testBad) begin
						failedTests++;
					end
					$display("test %-10s %s", name, testBad ? "failed" : "ok");
					testBad = 1'b0;
				end
			end
		end
	end

	task automatic report();
		$display("tests %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
	endtask

endmodule

//--- tb/mvu_asserts.sv
/*
 * MVU assertions
 * Reset, valid timing and stall hold checks, bound to the top level
 */

`timescale 1ns/1ps

module mvuAsserts import mvuPkg::*; (
	input logic clk,
	input logic rst,
	input logic en_i,
	input beatCtrl_t ctrl_i,
	input logic valid_o,
	input accuVec_t result_o
);

	logic [2:0] lastHist; // Accepted last flags, newest in bit 0

	always_ff @(posedge clk) begin
		if (rst) begin
			lastHist <= '0;
		end else if (en_i) begin
			lastHist <= {lastHist[1:0], ctrl_i.last};
		end
	end

	validLowInReset: assert property (@(posedge clk) rst |=> !valid_o)
		else $error("valid_o high right after reset");

	validFollowsLast: assert property (@(posedge clk) disable iff (rst)
		valid_o |-> lastHist[2])
		else $error("valid_o high without a last beat three enabled edges earlier");

	holdOnStall: assert property (@(posedge clk) disable iff (rst)
		!en_i |=> ($stable(valid_o) && $stable(result_o)))
		else $error("outputs changed while en_i was low");

endmodule

bind mvuTop mvuAsserts uAsserts (
	.clk(clk),
	.rst(rst),
	.en_i(en_i),
	.ctrl_i(ctrl_i),
	.valid_o(valid_o),
	.result_o(result_o)
);

//--- tb/mvuTb.sv
/*
 * MVU testbench
 * Reads beats and expected totals from the pattern file, drives the
 * DUT with optional random stalls, waits for every result and ends the
 * run, bounded by a watchdog
 */

`timescale 1ns/1ps

`include "mvu_config.svh"

module mvuTb import mvuPkg::*; ();

	localparam int ACT_BITS = `MVU_SIMD * `MVU_ACT_WIDTH;
	localparam int ROW_BITS = `MVU_SIMD * `MVU_WEIGHT_WIDTH;

	logic clk;
	logic rst;
	logic en_i;
	beatCtrl_t ctrl_i;
	actVec_t act_i;
	weightMat_t weight_i;
	logic valid_o;
	accuVec_t result_o;

	actVec_t beatAct [$];
	weightMat_t beatWeight [$];
	beatCtrl_t beatCtrl [$];
	bit beatStall [$]; // Beat may be preceded by a stall cycle
	logic loaded = 1'b0;
	logic [31:0] lfsr = 32'hd30b1ca0;

	tbClock uClock (.clk_o(clk));

	mvuTop UUT (
		.clk(clk),
		.rst(rst),
		.en_i(en_i),
		.ctrl_i(ctrl_i),
		.act_i(act_i),
		.weight_i(weight_i),
		.valid_o(valid_o),
		.result_o(result_o)
	);

	mvuChecker uChecker (
		.clk(clk),
		.rst(rst),
		.en_i(en_i),
		.valid_o(valid_o),
		.result_o(result_o)
	);

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] stepLfsr(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic loadPatterns(output bit ok);
		int fd;
		int code;
		int stall;
		int last;
		int zero;
		int e0;
		int e1;
		string line;
		string kind;
		string name;
		logic [ACT_BITS-1:0] aRaw;
		logic [ROW_BITS-1:0] w0Raw;
		logic [ROW_BITS-1:0] w1Raw;
		beatCtrl_t c;
		weightMat_t wm;
		accuVec_t expv;
		ok = 1'b1;
		fd = $fopen("tb/mvu_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/mvu_patterns.txt");
			ok = 1'b0;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				kind = "";
				code = $fgets(line, fd);
				code = $sscanf(line, "%s", kind);
				if (kind == "B") begin // Beat line
					code = $sscanf(line, "%s %s %d %d %d %h %h %h", kind, name, stall, last,
						zero, aRaw, w0Raw, w1Raw);
					if (code != 8) begin
						$display("malformed beat line: %s", line);
						ok = 1'b0;
					end
					c.last = last[0];
					c.zero = zero[0];
					wm[0] = weightVec_t'(w0Raw);
					wm[1] = weightVec_t'(w1Raw);
					beatAct.push_back(actVec_t'(aRaw));
					beatWeight.push_back(wm);
					beatCtrl.push_back(c);
					beatStall.push_back(stall != 0);
				end else if (kind == "E") begin // Expected totals
					code = $sscanf(line, "%s %s %d %d", kind, name, e0, e1);
					if (code != 4) begin
						$display("malformed expect line: %s", line);
						ok = 1'b0;
					end
					expv[0] = e0[`MVU_ACCU_WIDTH-1:0];
					expv[1] = e1[`MVU_ACCU_WIDTH-1:0];
					uChecker.addExpect(name, expv);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic applyBeat(input int i);
		if (beatStall[i]) begin
			lfsr = stepLfsr(lfsr);
			if (lfsr[0]) begin
				@(posedge clk);
				en_i <= 1'b0; // Stall with junk that must be ignored
				ctrl_i <= '{last: 1'b1, zero: 1'b0};
				act_i <= ~beatAct[i];
			end
		end
		@(posedge clk);
		en_i <= 1'b1;
		ctrl_i <= beatCtrl[i];
		act_i <= beatAct[i];
		weight_i <= beatWeight[i];
	endtask

	task automatic runTests();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < beatAct.size(); i++) begin
			applyBeat(i);
		end
		@(posedge clk);
		en_i <= 1'b1; // Idle beats flush the pipeline
		ctrl_i <= '0;
		act_i <= '0;
		weight_i <= '0;
		while (uChecker.pending() > 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk); // Catch any stray valid
		uChecker.report();
		if (uChecker.errorCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	endtask

	initial begin : stimulus
		bit ok;
		rst = 1'b1;
		en_i = 1'b1;
		ctrl_i = '0;
		act_i = '0;
		weight_i = '0;
		loadPatterns(ok);
		loaded = 1'b1;
		if (!ok) begin
			$display("pattern file could not be used");
			$display("TB FAILED");
			$finish;
		end else begin
			runTests();
		end
	end

	// Four cycles per beat covers stalls and pipeline latency
	initial begin : watchdog
		int limit;
		wait (loaded);
		limit = beatAct.size() * 4 + 50;
		repeat (limit) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", limit);
		$display("TB FAILED");
		$finish;
	end

endmodule

//--- tb/mvu_patterns.txt
# B name stall last zero act[23:0] w_pe0[23:0] w_pe1[23:0]  (hex, lane 5 leftmost)
# E name total_pe0 total_pe1  (signed decimal)
B single  0 1 0 123456 111111 ffffff
E single  21 -21
B signs   0 1 0 f87123 7f8123 888888
E signs   -41 -32
B multi   0 0 0 111111 222222 010101
B multi   0 0 0 333333 111111 ffffff
B multi   0 1 0 200002 300004 777777
E multi   44 13
B restart 0 1 0 010000 050000 0c0000
E restart 5 -4
B zero    0 0 1 777777 777777 777777
B zero    0 1 0 111111 123123 ff0000
E zero    12 -2
B zerolast 0 0 0 222222 111111 100000
B zerolast 0 1 1 777777 777777 777777
E zerolast 12 2
B b2b     0 1 0 000001 000007 000009
B b2b     0 1 0 000010 000020 000030
B b2b     0 1 0 100000 f00000 800000
E b2b     7 -7
E b2b     2 3
E b2b     -1 -8
B stall   1 0 0 765432 111111 ffffff
B stall   1 1 0 888888 111111 010000
B stall   1 1 0 7f7f7f 777777 888888
E stall   -21 -35
E stall   126 -144

//--- files.f
+incdir+verilog
verilog/mvu_pkg.sv
verilog/mvuControl.sv
verilog/dspSlice.sv
verilog/peChain.sv
verilog/mvuTop.sv
tb/tbClock.sv
tb/mvuChecker.sv
tb/mvu_asserts.sv
tb/mvuTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the MVU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module mvuTb -o VmvuTb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/VmvuTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

if ! grep -q "TB PASSED" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0
